/* files.f */
+incdir+include
source/console_char_pkg.sv
source/console_bus_pkg.sv
source/char_memory.sv
source/mem_arbiter.sv
source/text_editor.sv
source/frame_scanner.sv
source/char_console.sv
verification/tb_clock.sv
verification/tb_char_console.sv

/* include/console_params.svh */
// Console geometry and memory sizes, shared by RTL and testbench
// CON_COLS and CON_BUF_ROWS must be powers of two
// CON_MEM_CELLS must equal CON_COLS * CON_BUF_ROWS
// CON_ROWS must be less than CON_BUF_ROWS
`ifndef CONSOLE_PARAMS_SVH
`define CONSOLE_PARAMS_SVH

`define CON_COLS        8   // Columns per text row
`define CON_ROWS        3   // Visible text rows per frame
`define CON_BUF_ROWS    4   // Rows in the memory ring
`define CON_FONT_LINES  2   // Pixel lines per text row

`define CON_ADDR_W      5   // Character memory address bits
`define CON_CHAR_W      8   // Bits per character code
`define CON_MEM_CELLS   32  // Character memory depth

`endif

/* source/char_console.sv */
// Console character buffer top level
// Writer and frame reader share one single-port memory, writer first
// Sizes come from the macro header, no parameters here
`timescale 1ns/100ps

module char_console (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_char_stb,
  input  console_char_pkg::char_t  i_char,
  input  logic                     i_alt_func_en,
  input  logic                     i_clear_screen_stb,
  output logic                     o_wr_char_rdy,
  input  logic                     i_read_frame_stb,
  input  logic                     i_char_req_en,
  output logic                     o_char_rdy,
  output console_char_pkg::char_t  o_char
);
  import console_char_pkg::*;
  import console_bus_pkg::*;

  mem_req_t wr_req;    // Writer to arbiter
  mem_req_t rd_req;    // Reader to arbiter
  mem_req_t mem_req;   // Granted request
  logic     wr_grant;
  logic     rd_grant;
  char_t    rdata;
  row_t     top_row;   // Frame start row from writer

  text_editor editor_i (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_clear_screen_stb (i_clear_screen_stb),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .o_mem_req          (wr_req),
    .i_grant            (wr_grant),
    .o_top_row          (top_row)
  );

  frame_scanner scanner_i (
    .clk              (clk),
    .rst              (rst),
    .i_read_frame_stb (i_read_frame_stb),
    .i_char_req_en    (i_char_req_en),
    .i_top_row        (top_row),
    .o_mem_req        (rd_req),
    .i_grant          (rd_grant),
    .i_rdata          (rdata),
    .o_char_rdy       (o_char_rdy),
    .o_char           (o_char)
  );

  mem_arbiter arb_i (
    .i_wr_req   (wr_req),
    .i_rd_req   (rd_req),
    .o_wr_grant (wr_grant),
    .o_rd_grant (rd_grant),
    .o_mem_req  (mem_req)
  );

  char_memory mem_i (
    .clk     (clk),
    .i_req   (mem_req),
    .o_rdata (rdata)
  );

endmodule

/* source/char_memory.sv */
// Single-port character RAM
// Read data registered, valid the cycle after a granted read
// Holds the last read value until the next read; no reset on contents
`timescale 1ns/100ps
`include "console_params.svh"

module char_memory (
  input  logic                       clk,
  input  console_bus_pkg::mem_req_t  i_req,
  output console_char_pkg::char_t    o_rdata
);
  import console_char_pkg::*;

  char_t mem [`CON_MEM_CELLS];  // One cell per screen position in the ring

  always_ff @(posedge clk) begin
    if (i_req.valid) begin
      if (i_req.we) begin
        mem[i_req.addr] <= i_req.data;
      end else begin
        o_rdata <= mem[i_req.addr];  // Read latency of one cycle
      end
    end
  end

endmodule

/* source/console_bus_pkg.sv */
// Memory-side types for the single character memory port
// A request holds until the cycle it is granted
// cell_addr assumes row-major layout, CON_COLS cells per ring row
`include "console_params.svh"

package console_bus_pkg;

  import console_char_pkg::char_t;

  typedef logic [`CON_ADDR_W-1:0]            addr_t;  // Memory cell address
  typedef logic [$clog2(`CON_COLS)-1:0]      col_t;   // Column in a text row
  typedef logic [$clog2(`CON_BUF_ROWS)-1:0]  row_t;   // Row in the memory ring

  // One memory access, 15 bits
  typedef struct packed {
    logic  valid;  // Request present
    logic  we;     // 1 write, 0 read
    addr_t addr;
    char_t data;   // Write data, unused on reads
  } mem_req_t;

  // Cell address of ring row and column
  function automatic addr_t cell_addr(row_t row, col_t col);
    return addr_t'(row * `CON_COLS + col);
  endfunction

endpackage

/* source/console_char_pkg.sv */
// Character codes known to the console
// Only BS, CR and LF act as controls, other codes below 0x20 and DEL are dropped
// unless the alternate function input is high
`include "console_params.svh"

package console_char_pkg;

  typedef logic [`CON_CHAR_W-1:0] char_t;  // One character code

  // Control codes
  localparam char_t BS  = 8'h08;  // Backspace
  localparam char_t LF  = 8'h0A;  // Line feed
  localparam char_t CR  = 8'h0D;  // Carriage return
  localparam char_t BEL = 8'h07;  // Bell, ignored in normal mode

  // Printable range is FIRST_PRINT and up, DEL excluded
  localparam char_t FIRST_PRINT = 8'h20;
  localparam char_t DEL         = 8'h7F;

endpackage

/* source/frame_scanner.sv */
// Reader side: streams one frame, CON_ROWS text rows from the top row,
// each row repeated once per font line, one character in flight at a time
// Top row sampled at frame start; a new strobe restarts the frame
// o_char_rdy pulses one cycle, the cycle after the read is granted
`timescale 1ns/100ps
`include "console_params.svh"

module frame_scanner (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_read_frame_stb,
  input  logic                       i_char_req_en,
  input  console_bus_pkg::row_t      i_top_row,
  output console_bus_pkg::mem_req_t  o_mem_req,
  input  logic                       i_grant,
  input  console_char_pkg::char_t    i_rdata,
  output logic                       o_char_rdy,
  output console_char_pkg::char_t    o_char
);
  import console_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,  // Read request out
    ST_WAIT    // Read data on i_rdata
  } state_t;

  state_t state;
  row_t   ring_row;  // Current ring row
  row_t   vis_cnt;   // Visible rows done
  logic [$clog2(`CON_FONT_LINES)-1:0] line_cnt;  // Font line in the row
  col_t   col;
  logic   armed;     // Request raised but not granted yet, hold it

  // Read request, held once raised even if i_char_req_en drops
  assign o_mem_req = '{valid: (state == ST_FETCH) && (i_char_req_en || armed),
                       we: 1'b0, addr: cell_addr(ring_row, col), data: '0};

  assign o_char_rdy = (state == ST_WAIT);
  assign o_char     = i_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      armed    <= 1'b0;
      ring_row <= '0;
      vis_cnt  <= '0;
      line_cnt <= '0;
      col      <= '0;
    end else if (i_read_frame_stb) begin
      state    <= ST_FETCH;  // Start or restart
      armed    <= 1'b0;
      ring_row <= i_top_row;
      vis_cnt  <= '0;
      line_cnt <= '0;
      col      <= '0;
    end else begin
      case (state)
        ST_FETCH: begin
          armed <= o_mem_req.valid && !i_grant;  // Lost to the writer
          if (i_grant) state <= ST_WAIT;
        end

        ST_WAIT: begin
          state <= ST_FETCH;
          if (col != col_t'(`CON_COLS - 1)) begin
            col <= col + 1'b1;
          end else begin
            col <= '0;
            if (line_cnt != (`CON_FONT_LINES - 1)) begin
              line_cnt <= line_cnt + 1'b1;  // Same row again
            end else begin
              line_cnt <= '0;
              ring_row <= row_t'((ring_row + 1) % `CON_BUF_ROWS);
              if (vis_cnt == row_t'(`CON_ROWS - 1)) begin
                state <= ST_IDLE;  // Frame complete
              end else begin
                vis_cnt <= vis_cnt + 1'b1;
              end
            end
          end
        end

        default: state <= ST_IDLE;  // Wait for frame strobe
      endcase
    end
  end

endmodule

/* source/mem_arbiter.sv */
// Fixed-priority arbiter for the character memory port
// Writer always wins, reader only gets idle cycles
// Purely combinational, grant and forwarded request in the same cycle
`timescale 1ns/100ps

module mem_arbiter (
  input  console_bus_pkg::mem_req_t  i_wr_req,
  input  console_bus_pkg::mem_req_t  i_rd_req,
  output logic                       o_wr_grant,
  output logic                       o_rd_grant,
  output console_bus_pkg::mem_req_t  o_mem_req
);

  // Writer first
  assign o_wr_grant = i_wr_req.valid;

  // Reader only when writer is quiet
  assign o_rd_grant = i_rd_req.valid && !i_wr_req.valid;

  // Mux the winner onto the port, an invalid reader request passes as no-op
  always_comb begin
    if (i_wr_req.valid) begin
      o_mem_req = i_wr_req;
    end else begin
      o_mem_req = i_rd_req;
    end
  end

endmodule

/* source/text_editor.sv */
// Writer side of the console: decodes characters, moves the cursor,
// erases rows and clears the memory
// A new row is always erased before use; frame top follows the cursor
// Reset starts a full clear, o_wr_char_rdy stays low until it ends
`timescale 1ns/100ps
`include "console_params.svh"

module text_editor (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_char_stb,
  input  console_char_pkg::char_t    i_char,
  input  logic                       i_alt_func_en,
  input  logic                       i_clear_screen_stb,
  output logic                       o_wr_char_rdy,
  output console_bus_pkg::mem_req_t  o_mem_req,
  input  logic                       i_grant,
  output console_bus_pkg::row_t      o_top_row
);
  import console_char_pkg::*;
  import console_bus_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,   // Printable char in flight
    ST_ERASE,   // Blanking the new cursor row
    ST_BKSP,    // Single write, or none, then back to idle
    ST_CLEAR    // Whole memory to zero
  } state_t;

  state_t   state;
  col_t     cur_col;     // Cursor column
  row_t     cur_row;     // Cursor ring row
  row_t     adv_cnt;     // Row advances since clear, saturates
  col_t     er_col;      // Erase progress in the row
  logic     clear_pend;  // Clear strobe seen, not yet run
  mem_req_t req;

  row_t     next_row;
  row_t     next_adv;
  mem_req_t adv_req;     // First erase write of the next row
  logic     is_print;
  logic     is_bs;
  logic     is_nl;
  logic     req_done;

  // Character decode
  assign is_bs    = (i_char == BS);
  assign is_nl    = (i_char == CR) || (i_char == LF);
  assign is_print = i_alt_func_en || ((i_char >= FIRST_PRINT) && (i_char != DEL));

  assign next_row = row_t'((cur_row + 1) % `CON_BUF_ROWS);  // Ring wrap
  assign next_adv = (adv_cnt == row_t'(`CON_ROWS - 1)) ? adv_cnt : adv_cnt + 1'b1;
  assign adv_req  = '{valid: 1'b1, we: 1'b1, addr: cell_addr(next_row, '0), data: '0};
  assign req_done = !req.valid || i_grant;  // No request counts as done

  // Frame ends at cursor row
  assign o_top_row = row_t'((cur_row + `CON_BUF_ROWS - adv_cnt) % `CON_BUF_ROWS);

  assign o_wr_char_rdy = (state == ST_IDLE) && !clear_pend;
  assign o_mem_req     = req;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_CLEAR;  // Clear after reset
      req        <= '{valid: 1'b1, we: 1'b1, addr: '0, data: '0};
      cur_col    <= '0;
      cur_row    <= '0;
      adv_cnt    <= '0;
      er_col     <= '0;
      clear_pend <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (clear_pend) begin
            clear_pend <= 1'b0;
            cur_col    <= '0;
            cur_row    <= '0;
            adv_cnt    <= '0;
            req        <= '{valid: 1'b1, we: 1'b1, addr: '0, data: '0};
            state      <= ST_CLEAR;
          end else if (i_char_stb) begin
            if (is_print) begin
              req   <= '{valid: 1'b1, we: 1'b1, addr: cell_addr(cur_row, cur_col),
                         data: i_char};
              state <= ST_WRITE;
            end else if (is_bs && (cur_col != '0)) begin
              // Step back and blank that cell
              cur_col <= cur_col - 1'b1;
              req     <= '{valid: 1'b1, we: 1'b1,
                           addr: cell_addr(cur_row, cur_col - 1'b1), data: '0};
              state   <= ST_BKSP;
            end else if (is_nl) begin
              cur_row <= next_row;  // CR and LF alike
              cur_col <= '0;
              adv_cnt <= next_adv;
              req     <= adv_req;
              state   <= ST_ERASE;
            end else begin
              state <= ST_BKSP;  // Ignored code or BS at column 0, no write
            end
          end
        end

        ST_WRITE: begin
          if (i_grant) begin
            if (cur_col == col_t'(`CON_COLS - 1)) begin
              // Wrap, next row gets erased right away
              cur_row <= next_row;
              cur_col <= '0;
              adv_cnt <= next_adv;
              req     <= adv_req;
              state   <= ST_ERASE;
            end else begin
              cur_col   <= cur_col + 1'b1;
              req.valid <= 1'b0;
              state     <= ST_IDLE;
            end
          end
        end

        ST_ERASE: begin
          if (i_grant) begin
            er_col <= er_col + 1'b1;  // Rolls back to 0 after last column
            if (er_col == col_t'(`CON_COLS - 1)) begin
              req.valid <= 1'b0;
              state     <= ST_IDLE;
            end else begin
              req.addr <= req.addr + 1'b1;
            end
          end
        end

        ST_BKSP: begin
          if (req_done) begin
            req.valid <= 1'b0;
            state     <= ST_IDLE;
          end
        end

        ST_CLEAR: begin
          if (i_grant) begin
            if (req.addr == addr_t'(`CON_MEM_CELLS - 1)) begin
              req.valid <= 1'b0;
              state     <= ST_IDLE;
            end else begin
              req.addr <= req.addr + 1'b1;
            end
          end
        end

        default: state <= ST_IDLE;
      endcase

      if (i_clear_screen_stb) clear_pend <= 1'b1;  // Remembered in any state
    end
  end

endmodule

/* verification/tb_char_console.sv */
// Testbench for the console character buffer
// Steps come from a table and expected frames from a shadow ring model
// Inputs change and outputs are sampled 2 ns after each rising edge
// Frame reads see LFSR back-pressure on i_char_req_en with seed 97
`timescale 1ns/100ps
`include "console_params.svh"

module tb_char_console;
  import console_char_pkg::*;

  localparam int CLK_PERIOD  = 40;   // ns
  localparam int STEP_CYCLES = 400;  // Watchdog budget per step
  localparam int COLS        = `CON_COLS;
  localparam int ROWS        = `CON_ROWS;
  localparam int BUF_ROWS    = `CON_BUF_ROWS;
  localparam int FONT_LINES  = `CON_FONT_LINES;
  localparam int FRAME_LEN   = ROWS * FONT_LINES * COLS;

  typedef enum logic [1:0] {OP_CHAR, OP_CLEAR, OP_FRAME} op_t;

  typedef struct packed {
    op_t   op;
    char_t code;  // Used by OP_CHAR only
    logic  alt;   // Alternate function for a literal write
  } step_t;

  logic  clk;
  logic  rst;
  logic  i_char_stb;
  char_t i_char;
  logic  i_alt_func_en;
  logic  i_clear_screen_stb;
  logic  o_wr_char_rdy;
  logic  i_read_frame_stb;
  logic  i_char_req_en;
  logic  o_char_rdy;
  char_t o_char;

  step_t      steps[$];
  logic       steps_loaded = 1'b0;
  logic [7:0] lfsr = 8'd97;
  char_t      shadow [BUF_ROWS][COLS];  // Expected memory contents
  int         cur_row;
  int         cur_col;
  int         top_row;                  // First ring row of the frame
  int         used_rows;                // Rows in use since clear, up to ROWS

  tb_clock clock_i (.clk(clk), .rst(rst));

  char_console char_console_i (
    .clk                (clk),
    .rst                (rst),
    .i_char_stb         (i_char_stb),
    .i_char             (i_char),
    .i_alt_func_en      (i_alt_func_en),
    .i_clear_screen_stb (i_clear_screen_stb),
    .o_wr_char_rdy      (o_wr_char_rdy),
    .i_read_frame_stb   (i_read_frame_stb),
    .i_char_req_en      (i_char_req_en),
    .o_char_rdy         (o_char_rdy),
    .o_char             (o_char)
  );

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "Stopped at the first failure");
  endtask

  // Galois LFSR with polynomial x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // Advance to the next sample and drive point
  task automatic next_cycle();
    @(posedge clk);
    #2;
    lfsr          = lfsr_step(lfsr);
    i_char_req_en = lfsr[0];  // One back-pressure bit per cycle
  endtask

  function automatic void add_step(op_t op, char_t code, logic alt);
    steps.push_back('{op, code, alt});
  endfunction

  function automatic void add_text(string s);
    for (int i = 0; i < s.len(); i++) begin
      add_step(OP_CHAR, char_t'(s[i]), 1'b0);
    end
  endfunction

  function automatic void model_clear();
    foreach (shadow[r, c]) shadow[r][c] = '0;
    cur_row   = 0;
    cur_col   = 0;
    top_row   = 0;
    used_rows = 1;
  endfunction

  // New row is blanked before use
  function automatic void model_new_row();
    cur_row = (cur_row + 1) % BUF_ROWS;
    cur_col = 0;
    if (used_rows < ROWS) begin
      used_rows++;                         // Frame still has room below
    end else begin
      top_row = (top_row + 1) % BUF_ROWS;  // Scroll so the frame ends at the cursor
    end
    for (int c = 0; c < COLS; c++) begin
      shadow[cur_row][c] = '0;
    end
  endfunction

  function automatic void model_char(char_t code, logic alt);
    if (alt || ((code >= FIRST_PRINT) && (code != DEL))) begin
      shadow[cur_row][cur_col] = code;
      if (cur_col == COLS - 1) model_new_row();  // Wrap
      else cur_col++;
    end else if (code == BS) begin
      if (cur_col > 0) begin
        cur_col--;
        shadow[cur_row][cur_col] = '0;
      end
    end else if ((code == CR) || (code == LF)) begin
      model_new_row();
    end
  endfunction

  // Maps a frame index to its shadow cell
  function automatic char_t expected_char(int idx);
    int vis;
    vis = idx / (COLS * FONT_LINES);  // Each row repeats once per font line
    return shadow[(top_row + vis) % BUF_ROWS][idx % COLS];
  endfunction

  task automatic wait_char_ready();
    while (!o_wr_char_rdy) next_cycle();
  endtask

  task automatic send_char(char_t code, logic alt);
    wait_char_ready();
    i_char        = code;
    i_alt_func_en = alt;
    i_char_stb    = 1'b1;
    next_cycle();                // Accepted on that edge
    i_char_stb    = 1'b0;
    assert (o_wr_char_rdy === 1'b0) else begin
      $display("ERROR: o_wr_char_rdy expected 0 got %h after char %h", o_wr_char_rdy, code);
      stop_on_error();
    end
    wait_char_ready();           // All writes granted
    model_char(code, alt);
  endtask

  task automatic clear_screen();
    wait_char_ready();
    i_clear_screen_stb = 1'b1;
    next_cycle();
    i_clear_screen_stb = 1'b0;
    assert (o_wr_char_rdy === 1'b0) else begin
      $display("ERROR: o_wr_char_rdy expected 0 got %h after clear", o_wr_char_rdy);
      stop_on_error();
    end
    wait_char_ready();
    model_clear();
  endtask

  task automatic read_frame();
    int got;
    got = 0;
    i_read_frame_stb = 1'b1;
    next_cycle();
    i_read_frame_stb = 1'b0;
    while (got < FRAME_LEN) begin
      if (o_char_rdy) begin      // One pulse per character
        assert (o_char === expected_char(got)) else begin
          $display("ERROR: o_char index %0d expected %h got %h",
                   got, expected_char(got), o_char);
          stop_on_error();
        end
        got++;
      end
      next_cycle();
    end
  endtask

  initial begin : watchdog
    wait (steps_loaded);
    #(steps.size() * STEP_CYCLES * CLK_PERIOD);
    $display("Run timed out, the DUT stopped responding before all steps were done");
    stop_on_error();
  end

  initial begin
    i_char_stb         = 1'b0;
    i_char             = '0;
    i_alt_func_en      = 1'b0;
    i_clear_screen_stb = 1'b0;
    i_read_frame_stb   = 1'b0;
    i_char_req_en      = 1'b0;
    model_clear();

    add_step(OP_FRAME, '0, 1'b0);          // Blank after reset clear
    add_text("ABC");
    add_step(OP_FRAME, '0, 1'b0);
    add_step(OP_CHAR, BS, 1'b0);           // Erase C
    add_step(OP_FRAME, '0, 1'b0);
    add_step(OP_CHAR, BS, 1'b0);
    add_step(OP_CHAR, BS, 1'b0);
    add_step(OP_CHAR, BS, 1'b0);           // At column 0 with no effect
    add_step(OP_FRAME, '0, 1'b0);
    add_step(OP_CHAR, CR, 1'b0);
    add_text("x");
    add_step(OP_CHAR, LF, 1'b0);
    add_text("123456789");                 // Wraps into the next row
    add_step(OP_CHAR, BEL, 1'b0);          // Ignored
    add_step(OP_CHAR, DEL, 1'b0);          // Ignored
    add_step(OP_FRAME, '0, 1'b0);
    add_step(OP_CHAR, BEL, 1'b1);          // Stored literally
    add_step(OP_FRAME, '0, 1'b0);
    add_step(OP_CHAR, LF, 1'b0);           // Reuses ring row 0
    add_text("p");
    add_step(OP_CHAR, LF, 1'b0);
    add_text("q");
    add_step(OP_CHAR, CR, 1'b0);
    add_text("r");
    add_step(OP_FRAME, '0, 1'b0);
    add_step(OP_CLEAR, '0, 1'b0);
    add_step(OP_FRAME, '0, 1'b0);
    add_text("Z");                         // Lands at row 0 column 0
    add_step(OP_FRAME, '0, 1'b0);
    steps_loaded = 1'b1;

    @(negedge rst);
    next_cycle();
    assert ((o_wr_char_rdy === 1'b0) && (o_char_rdy === 1'b0)) else begin
      $display("ERROR: after reset o_wr_char_rdy %h o_char_rdy %h, expected 0 and 0",
               o_wr_char_rdy, o_char_rdy);
      stop_on_error();
    end
    wait_char_ready();                     // Reset clear done

    foreach (steps[i]) begin
      case (steps[i].op)
        OP_CHAR:  send_char(steps[i].code, steps[i].alt);
        OP_CLEAR: clear_screen();
        default:  read_frame();
      endcase
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
// Testbench clock and reset source
// 40 ns period, reset high for the first 5 rising edges
// Reset drops 2 ns after an edge, in step with the stimulus
`timescale 1ns/100ps

module tb_clock (
  output logic clk,
  output logic rst
);
  localparam int HALF_PERIOD = 20;  // ns
  localparam int RST_CYCLES  = 5;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst = 1'b0;  // Off the edge, no race with DUT sampling
  end

endmodule
